// ==== src/board_pkg.sv ====
// Board input definitions
package board_pkg;

    localparam int NUM_PLAYERS = 4;    // joystick ports on the board
    localparam int JOY_W       = 16;   // board joystick word
    localparam int GAME_JOY_W  = 10;   // what the game core sees
    localparam int DIR_W       = 4;    // right, left, down, up

    // bit 0 right, 1 left, 2 down, 3 up, buttons from bit 4
    typedef logic [JOY_W-1:0]       joy_word_t;
    typedef logic [GAME_JOY_W-1:0]  game_joy_t;
    typedef logic [DIR_W-1:0]       dir_t;
    typedef logic [NUM_PLAYERS-1:0] player_mask_t;   // player 1 in bit 0

    // start, coin and pause sit right after the game buttons
    function automatic int start_bit(input int buttons);
        return 4 + buttons;
    endfunction

    function automatic int coin_bit(input int buttons);
        return 5 + buttons;
    endfunction

    function automatic int pause_bit(input int buttons);
        return 6 + buttons;
    endfunction

endpackage

// ==== src/joy_bus_if.sv ====
// Registered joystick bus
`timescale 1ns/1ns

interface joy_bus_if import board_pkg::*; ();

    // one word per player, valid every cycle
    joy_word_t joy [NUM_PLAYERS];

    modport src (
        output joy
    );

    modport dst (
        input joy
    );

endinterface

// ==== src/joy_4way_filter.sv ====
// Four-way direction filter
`timescale 1ns/1ns

module joy_4way_filter import board_pkg::*; (
    input  logic clk_sys,
    input  logic rst,
    input  logic enable,
    input  dir_t dir_in,
    output dir_t dir_out
);

    logic single_dir;

    // true for zero or one direction pressed
    assign single_dir = (dir_in & (dir_in - dir_t'(1))) == '0;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_out <= '0;
        end else if (!enable || single_dir) begin
            dir_out <= dir_in;
        end
        // diagonal with filter on keeps the last direction
    end

endmodule

// ==== src/joy_input_stage.sv ====
// Joystick input stage
`timescale 1ns/1ns

module joy_input_stage import board_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst,
    input  logic      en_4way,
    input  joy_word_t board_joy [NUM_PLAYERS],
    joy_bus_if.src    bus
);

    localparam int HI_W = JOY_W - DIR_W;   // buttons, coin, start, pause...

    logic [HI_W-1:0] hi_q  [NUM_PLAYERS];
    dir_t            dir_q [NUM_PLAYERS];

    for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_player

        // filter output doubles as the direction register
        joy_4way_filter u_filter (
            .clk_sys ( clk_sys                  ),
            .rst     ( rst                      ),
            .enable  ( en_4way                  ),
            .dir_in  ( board_joy[i][DIR_W-1:0]  ),
            .dir_out ( dir_q[i]                 )
        );

        always_ff @(posedge clk_sys) begin
            if (rst) begin
                hi_q[i] <= '0;
            end else begin
                hi_q[i] <= board_joy[i][JOY_W-1:DIR_W];
            end
        end

        // both halves are one cycle behind the board
        assign bus.joy[i] = {hi_q[i], dir_q[i]};

    end

endmodule

// ==== src/board_control.sv ====
// Pause and game reset control
`timescale 1ns/1ns

module board_control import board_pkg::*; #(
    parameter int BUTTONS         = 2,
    parameter int GAME_RST_CYCLES = 32
) (
    input  logic   clk_sys,
    input  logic   rst,
    input  logic   rst_req,
    input  logic   downloading,
    input  logic   key_reset,
    input  logic   key_pause,
    input  logic   osd_pause,
    joy_bus_if.dst bus,
    output logic   game_pause,
    output logic   game_rst
);

    localparam int PAUSE_B = pause_bit(BUTTONS);
    localparam int CNT_W   = $clog2(GAME_RST_CYCLES + 1);

    logic             joy_pause;
    logic             last_joy_pause;
    logic             last_key_pause;
    logic             last_osd_pause;
    logic             last_key_reset;
    logic             pause_rise;
    logic             soft_rst;
    logic             rst_cause;
    logic [CNT_W-1:0] rst_cnt;

    // only players 1 and 2 carry a pause button
    assign joy_pause = bus.joy[0][PAUSE_B] | bus.joy[1][PAUSE_B];

    assign pause_rise = (joy_pause && !last_joy_pause)
                      || (key_pause && !last_key_pause)
                      || (osd_pause && !last_osd_pause);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_joy_pause <= 1'b0;
            last_key_pause <= 1'b0;
            last_osd_pause <= 1'b0;
            last_key_reset <= 1'b0;
            soft_rst       <= 1'b0;
            game_pause     <= 1'b0;
        end else begin
            last_joy_pause <= joy_pause;
            last_key_pause <= key_pause;
            last_osd_pause <= osd_pause;
            last_key_reset <= key_reset;
            soft_rst       <= key_reset && !last_key_reset;   // one pulse per press
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (pause_rise) begin
                game_pause <= ~game_pause;
            end
        end
    end

    assign rst_cause = rst | rst_req | downloading | soft_rst;

    // reset stretcher, restarts on every cause
    always_ff @(posedge clk_sys) begin
        if (rst_cause) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt != CNT_W'(GAME_RST_CYCLES)) begin
            rst_cnt  <= rst_cnt + CNT_W'(1);
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

endmodule

// ==== src/joy_output_stage.sv ====
// Game joystick output stage
`timescale 1ns/1ns

module joy_output_stage import board_pkg::*; #(
    parameter int BUTTONS    = 2,
    parameter int ACTIVE_LOW = 1
) (
    input  logic         clk_sys,
    input  logic         rst,
    input  logic         rot_control,
    joy_bus_if.dst       bus,
    output game_joy_t    game_joy [NUM_PLAYERS],
    output player_mask_t game_coin,
    output player_mask_t game_start
);

    localparam int           START_B  = start_bit(BUTTONS);
    localparam int           COIN_B   = coin_bit(BUTTONS);
    localparam game_joy_t    JOY_INV  = (ACTIVE_LOW != 0) ? '1 : '0;
    localparam player_mask_t MASK_INV = (ACTIVE_LOW != 0) ? '1 : '0;

    // vertical games swap the axes
    function automatic game_joy_t rotate_joy(input game_joy_t j, input logic rot);
        game_joy_t r;
        r = rot ? {j[GAME_JOY_W-1:4], j[0], j[1], j[3], j[2]} : j;
        return r;
    endfunction

    player_mask_t coin_raw;
    player_mask_t start_raw;

    always_comb begin
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            coin_raw[i]  = bus.joy[i][COIN_B];
            start_raw[i] = bus.joy[i][START_B];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                game_joy[i] <= JOY_INV;   // idle level seen by the game
            end
            game_coin  <= MASK_INV;
            game_start <= MASK_INV;
        end else begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                game_joy[i] <= JOY_INV
                    ^ rotate_joy(bus.joy[i][GAME_JOY_W-1:0], rot_control);
            end
            game_coin  <= MASK_INV ^ coin_raw;
            game_start <= MASK_INV ^ start_raw;
        end
    end

endmodule

// ==== src/game_board.sv ====
// Board input and reset top level
`timescale 1ns/1ns

module game_board import board_pkg::*; #(
    parameter int BUTTONS         = 2,
    parameter int ACTIVE_LOW      = 1,
    parameter int GAME_RST_CYCLES = 32
) (
    input  logic         clk_sys,
    input  logic         rst,
    input  logic         rst_req,
    input  logic         downloading,
    input  logic         en_4way,
    input  logic         rot_control,
    input  logic         osd_pause,
    input  logic         key_reset,
    input  logic         key_pause,
    input  joy_word_t    board_joystick1,
    input  joy_word_t    board_joystick2,
    input  joy_word_t    board_joystick3,
    input  joy_word_t    board_joystick4,
    output game_joy_t    game_joystick1,
    output game_joy_t    game_joystick2,
    output game_joy_t    game_joystick3,
    output game_joy_t    game_joystick4,
    output player_mask_t game_coin,
    output player_mask_t game_start,
    output logic         game_pause,
    output logic         game_rst
);

    joy_word_t board_joy [NUM_PLAYERS];
    game_joy_t game_joy  [NUM_PLAYERS];

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

    joy_bus_if u_joy_bus ();

    joy_input_stage u_input (
        .clk_sys   ( clk_sys   ),
        .rst       ( rst       ),
        .en_4way   ( en_4way   ),
        .board_joy ( board_joy ),
        .bus       ( u_joy_bus )
    );

    board_control #(
        .BUTTONS         ( BUTTONS         ),
        .GAME_RST_CYCLES ( GAME_RST_CYCLES )
    ) u_control (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .key_reset   ( key_reset   ),
        .key_pause   ( key_pause   ),
        .osd_pause   ( osd_pause   ),
        .bus         ( u_joy_bus   ),
        .game_pause  ( game_pause  ),
        .game_rst    ( game_rst    )
    );

    joy_output_stage #(
        .BUTTONS    ( BUTTONS    ),
        .ACTIVE_LOW ( ACTIVE_LOW )
    ) u_output (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .rot_control ( rot_control ),
        .bus         ( u_joy_bus   ),
        .game_joy    ( game_joy    ),
        .game_coin   ( game_coin   ),
        .game_start  ( game_start  )
    );

endmodule

// ==== tests/tb_game_board.sv ====
// Game board testbench
`timescale 1ns/1ns

module tb_game_board import board_pkg::*; ();

    localparam int GAME_RST_CYCLES = 32;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_DIRECTED    = 17;
    localparam int NUM_RANDOM      = 12;
    localparam int NUM_ROWS        = NUM_DIRECTED + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 3 + RESET_CYCLES + 200;

    // control column bits from msb downloading osd_pause key_reset key_pause rot en_4way
    localparam logic [5:0] C_NONE = 6'b000000;
    localparam logic [5:0] C_EN4  = 6'b000001;
    localparam logic [5:0] C_ROT  = 6'b000010;
    localparam logic [5:0] C_KP   = 6'b000100;
    localparam logic [5:0] C_OP   = 6'b010000;
    localparam logic [5:0] C_DL   = 6'b100000;

    typedef struct packed {
        joy_word_t [3:0]    board;
        logic [5:0]         ctl;
        game_joy_t [3:0]    exp_joy;
        player_mask_t       exp_coin;
        player_mask_t       exp_start;
        logic               exp_pause;
    } row_t;

    logic clk_sys, rst, rst_req, downloading, en_4way, rot_control;
    logic osd_pause, key_reset, key_pause;
    joy_word_t board_joystick1, board_joystick2, board_joystick3, board_joystick4;
    game_joy_t game_joystick1, game_joystick2, game_joystick3, game_joystick4;
    player_mask_t game_coin, game_start;
    logic game_pause, game_rst;

    row_t        table_q [$];
    string       row_name [$];
    logic [31:0] lfsr_state = 32'hcc30_38d2;
    dir_t        dir_state [4];      // model of each filter register
    logic        model_pause = 1'b1;  // pause left set by the directed rows
    logic        model_src   = 1'b0;
    int          err_count    = 0;
    int          test_count   = 0;
    int          failed_tests = 0;

    game_board dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("timeout: simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[31]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic int bits_set(input dir_t d);
        int cnt;
        cnt = 0;
        for (int i = 0; i < 4; i++) begin
            if (d[i]) cnt++;
        end
        return cnt;
    endfunction

    // rotation puts right, left, up, down into bits 3..0, then active-low
    function automatic game_joy_t expected_joy(input joy_word_t w, input logic rot);
        dir_t d;
        d = w[3:0];
        if (rot) begin
            d = {w[0], w[1], w[3], w[2]};
        end
        return {w[9:4], d} ^ 10'h3ff;
    endfunction

    task automatic add_row(input string name, input joy_word_t b1, input joy_word_t b2,
                           input joy_word_t b3, input joy_word_t b4, input logic [5:0] ctl,
                           input game_joy_t e1, input game_joy_t e2, input game_joy_t e3,
                           input game_joy_t e4, input player_mask_t ec,
                           input player_mask_t es, input logic ep);
        row_t r;
        r.board   = {b4, b3, b2, b1};
        r.ctl     = ctl;
        r.exp_joy = {e4, e3, e2, e1};
        r.exp_coin  = ec;
        r.exp_start = es;
        r.exp_pause = ep;
        table_q.push_back(r);
        row_name.push_back(name);
    endtask

    task automatic add_random_rows(input int count);
        row_t        r;
        logic [31:0] bits;
        joy_word_t   w;
        logic        src;
        for (int n = 0; n < count; n++) begin
            for (int p = 0; p < 4; p++) begin
                take_bits(16, bits);
                r.board[p] = bits[15:0];
            end
            take_bits(2, bits);
            r.ctl = {4'b0000, bits[1:0]};   // only rot and en_4way vary
            for (int p = 0; p < 4; p++) begin
                if (!(r.ctl[0] && bits_set(r.board[p][3:0]) > 1)) begin
                    dir_state[p] = r.board[p][3:0];
                end
                w = {r.board[p][15:4], dir_state[p]};
                r.exp_joy[p]   = expected_joy(w, r.ctl[1]);
                r.exp_coin[p]  = ~w[7];
                r.exp_start[p] = ~w[6];
            end
            src = r.board[0][8] | r.board[1][8];   // pause buttons of players 1 and 2
            if (src && !model_src) begin
                model_pause = ~model_pause;
            end
            model_src   = src;
            r.exp_pause = model_pause;
            table_q.push_back(r);
            row_name.push_back("random");
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count != errs_before) begin
            failed_tests++;
        end
        $display("test %0d %s: %s", test_count, name,
                 (err_count == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic wait_game_rst_low(input int limit);
        int waited;
        waited = 0;
        while (game_rst && waited < limit) begin
            @(negedge clk_sys);
            waited++;
        end
        if (game_rst) begin
            $display("game_rst stayed high for more than %0d cycles", limit);
            err_count++;
        end
    endtask

    task automatic run_reset_test();
        int errs;
        errs = err_count;
        @(negedge clk_sys);
        check_value("game_rst", 32'(game_rst), 32'd1);
        check_value("game_joystick1", 32'(game_joystick1), 32'h3ff);   // idle after rst
        check_value("game_joystick2", 32'(game_joystick2), 32'h3ff);
        check_value("game_joystick3", 32'(game_joystick3), 32'h3ff);
        check_value("game_joystick4", 32'(game_joystick4), 32'h3ff);
        check_value("game_coin", 32'(game_coin), 32'hf);
        check_value("game_start", 32'(game_start), 32'hf);
        check_value("game_pause", 32'(game_pause), 32'd0);
        wait_game_rst_low(GAME_RST_CYCLES + 2);
        finish_test("state and game reset after rst", errs);
        errs = err_count;
        @(posedge clk_sys);
        key_reset <= 1'b1;
        @(posedge clk_sys);
        key_reset <= 1'b0;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("game_rst", 32'(game_rst), 32'd1);   // soft reset, then stretch
        wait_game_rst_low(GAME_RST_CYCLES + 2);
        finish_test("game reset on key_reset", errs);
        errs = err_count;
        @(posedge clk_sys);
        rst_req <= 1'b1;
        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("game_rst", 32'(game_rst), 32'd1);
        @(posedge clk_sys);
        rst_req <= 1'b0;
        wait_game_rst_low(GAME_RST_CYCLES + 2);
        finish_test("game reset on rst_req", errs);
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int   errs;
        r    = table_q[idx];
        errs = err_count;
        @(posedge clk_sys);
        board_joystick1 <= r.board[0];
        board_joystick2 <= r.board[1];
        board_joystick3 <= r.board[2];
        board_joystick4 <= r.board[3];
        en_4way     <= r.ctl[0];
        rot_control <= r.ctl[1];
        key_pause   <= r.ctl[2];
        key_reset   <= r.ctl[3];
        osd_pause   <= r.ctl[4];
        downloading <= r.ctl[5];
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);   // two register stages have settled
        check_value("game_joystick1", 32'(game_joystick1), 32'(r.exp_joy[0]));
        check_value("game_joystick2", 32'(game_joystick2), 32'(r.exp_joy[1]));
        check_value("game_joystick3", 32'(game_joystick3), 32'(r.exp_joy[2]));
        check_value("game_joystick4", 32'(game_joystick4), 32'(r.exp_joy[3]));
        check_value("game_coin", 32'(game_coin), 32'(r.exp_coin));
        check_value("game_start", 32'(game_start), 32'(r.exp_start));
        check_value("game_pause", 32'(game_pause), 32'(r.exp_pause));
        finish_test(row_name[idx], errs);
    endtask

    task automatic build_table();
        add_row("reset state", 16'h0000, 16'h0000, 16'h0000, 16'h0000, C_NONE,
                10'h3ff, 10'h3ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b0);
        add_row("pass-through", 16'h0031, 16'h0202, 16'h0004, 16'h0008, C_NONE,
                10'h3ce, 10'h1fd, 10'h3fb, 10'h3f7, 4'hf, 4'hf, 1'b0);
        add_row("rotation", 16'h0031, 16'h0202, 16'h0004, 16'h0008, C_ROT,
                10'h3c7, 10'h1fb, 10'h3fe, 10'h3fd, 4'hf, 4'hf, 1'b0);
        add_row("coin and start", 16'h0080, 16'h0040, 16'h00c0, 16'h0000, C_NONE,
                10'h37f, 10'h3bf, 10'h33f, 10'h3ff, 4'ha, 4'h9, 1'b0);
        add_row("4-way single", 16'h0001, 16'h0001, 16'h0001, 16'h0001, C_EN4,
                10'h3fe, 10'h3fe, 10'h3fe, 10'h3fe, 4'hf, 4'hf, 1'b0);
        add_row("4-way diagonal", 16'h0005, 16'h0002, 16'h000f, 16'h0000, C_EN4,
                10'h3fe, 10'h3fd, 10'h3fe, 10'h3ff, 4'hf, 4'hf, 1'b0);
        add_row("8-way diagonal", 16'h0005, 16'h0005, 16'h0005, 16'h0005, C_NONE,
                10'h3fa, 10'h3fa, 10'h3fa, 10'h3fa, 4'hf, 4'hf, 1'b0);
        add_row("p2 pause", 16'h0000, 16'h0100, 16'h0000, 16'h0000, C_NONE,
                10'h3ff, 10'h2ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b1);
        add_row("p2 pause held", 16'h0000, 16'h0100, 16'h0000, 16'h0000, C_NONE,
                10'h3ff, 10'h2ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b1);
        add_row("p2 pause release", 16'h0000, 16'h0000, 16'h0000, 16'h0000, C_NONE,
                10'h3ff, 10'h3ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b1);
        add_row("key pause", 16'h0000, 16'h0000, 16'h0000, 16'h0000, C_KP,
                10'h3ff, 10'h3ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b0);
        add_row("key pause held", 16'h0000, 16'h0000, 16'h0000, 16'h0000, C_KP,
                10'h3ff, 10'h3ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b0);
        add_row("osd pause", 16'h0000, 16'h0000, 16'h0000, 16'h0000, C_OP,
                10'h3ff, 10'h3ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b1);
        add_row("downloading", 16'h0000, 16'h0000, 16'h0000, 16'h0000, C_OP | C_DL,
                10'h3ff, 10'h3ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b0);
        add_row("download end", 16'h0000, 16'h0000, 16'h0000, 16'h0000, C_NONE,
                10'h3ff, 10'h3ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b0);
        add_row("p1 pause", 16'h0100, 16'h0000, 16'h0000, 16'h0000, C_NONE,
                10'h2ff, 10'h3ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b1);
        add_row("p1 pause release", 16'h0000, 16'h0000, 16'h0000, 16'h0000, C_NONE,
                10'h3ff, 10'h3ff, 10'h3ff, 10'h3ff, 4'hf, 4'hf, 1'b1);
        for (int p = 0; p < 4; p++) begin
            dir_state[p] = '0;   // last directed row left the filters at zero
        end
        add_random_rows(NUM_RANDOM);
    endtask

    initial begin
        rst = 1'b1;
        rst_req = 1'b0;
        downloading = 1'b0;
        en_4way = 1'b0;
        rot_control = 1'b0;
        osd_pause = 1'b0;
        key_reset = 1'b0;
        key_pause = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_joystick3 = '0;
        board_joystick4 = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_sys);
        rst <= 1'b0;
        run_reset_test();
        for (int i = 0; i < table_q.size(); i++) begin
            apply_row(i);
        end
        $display("%0d tests run, %0d failed, %0d mismatches", test_count, failed_tests,
                 err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/board_pkg.sv
src/joy_bus_if.sv
src/joy_4way_filter.sv
src/joy_input_stage.sv
src/board_control.sv
src/joy_output_stage.sv
src/game_board.sv
tests/tb_game_board.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing -f project.f --top-module tb_game_board -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or run error" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || grep -q "sim passed" sim.log
